//--- verilog/mmio_map_pkg.sv
`default_nettype none

package mmio_map_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // byte addresses, decode looks at bits 31:2 only
    localparam addr_t RAM_BASE = 32'h0000_0000;
    localparam addr_t KBD_ADDR = 32'h0000_1000;
    localparam addr_t SWT_ADDR = 32'h0000_1004;
    localparam addr_t RTC_ADDR = 32'h0000_1008;
    localparam addr_t SEG_ADDR = 32'h0000_1010;
    localparam addr_t LED_ADDR = 32'h0000_1014;

    localparam int KB_WIDTH = 8;

    // display word, digit 0 in the low nibble
    typedef union packed {
        word_t           raw;
        logic [7:0][3:0] digit;
    } seg_word_u;

    // segment a in bit 0 up to g in bit 6, active high
    typedef logic [7:0][6:0] seg_pattern_t;

    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_RAM,
        DEV_KBD,
        DEV_SWT,
        DEV_RTC,
        DEV_SEG,
        DEV_LED
    } dev_sel_e;

    // device access driven by the bus FSM
    typedef struct packed {
        dev_sel_e    sel;
        logic [29:0] word_addr;
        word_t       wdata;
        logic [3:0]  wstrb;
        logic        we;
        logic        re;
    } dev_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        mmio_map_pkg::addr_t addr;
        logic                valid;
    } axil_aw_t;

    typedef struct packed {
        mmio_map_pkg::word_t data;
        logic [3:0]          strb;
        logic                valid;
    } axil_w_t;

    typedef struct packed {
        mmio_map_pkg::addr_t addr;
        logic                valid;
    } axil_ar_t;

    typedef struct packed {
        axil_resp_e resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        mmio_map_pkg::word_t data;
        axil_resp_e          resp;
        logic                valid;
    } axil_r_t;

    // master to slave
    typedef struct packed {
        axil_aw_t aw;
        axil_w_t  w;
        axil_ar_t ar;
        logic     bready;
        logic     rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic    awready;
        logic    wready;
        logic    arready;
        axil_b_t b;
        axil_r_t r;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- verilog/mmio_ram.sv
`timescale 1ns/1ns
`default_nettype none

module mmio_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                    clk,
    input  mmio_map_pkg::dev_ctrl_t dev_ctrl,
    output mmio_map_pkg::word_t     rdata
);
    import mmio_map_pkg::*;

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic          hit;

    assign hit = (dev_ctrl.sel == DEV_RAM);
    // word index relative to the region base
    assign idx = AW'(dev_ctrl.word_addr - RAM_BASE[31:2]);

    always_ff @(posedge clk) begin
        if (hit && dev_ctrl.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dev_ctrl.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= dev_ctrl.wdata[8*b +: 8];
                end
            end
        end
        // synchronous read, one cycle latency
        if (hit && dev_ctrl.re) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/kbd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module kbd_fifo #(
    parameter int KBD_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mmio_map_pkg::KB_WIDTH-1:0] kb_code,
    input  logic                              kb_valid,
    input  logic                              pop,
    output logic [mmio_map_pkg::KB_WIDTH-1:0] rdata,
    output logic                              empty
);
    import mmio_map_pkg::*;

    localparam int PW = (KBD_DEPTH > 1) ? $clog2(KBD_DEPTH) : 1;
    localparam int CW = $clog2(KBD_DEPTH + 1);

    logic [KB_WIDTH-1:0] mem [KBD_DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(KBD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CW'(KBD_DEPTH));
    assign empty   = (count == '0);
    // a code arriving while full is lost
    assign do_push = kb_valid && !full;
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= kb_code;
    end

endmodule

`default_nettype wire

//--- verilog/rtc_counter.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_counter #(
    parameter int RTC_DIV = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    output mmio_map_pkg::word_t count
);

    localparam int PW = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

    logic [PW-1:0] pre;
    logic          tick;

    // one tick per RTC_DIV clocks
    assign tick = (pre == PW'(RTC_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre   <= '0;
            count <= '0;
        end else begin
            pre <= tick ? '0 : pre + 1'b1;
            // wraps at the top of the range
            if (tick) count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/periph_regs.sv
`timescale 1ns/1ns
`default_nettype none

module periph_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mmio_map_pkg::dev_ctrl_t    dev_ctrl,
    input  logic [7:0]                 sw,
    output logic [7:0]                 swt_rdata,
    output mmio_map_pkg::word_t        seg_rdata,
    output logic [15:0]                led_rdata,
    output mmio_map_pkg::seg_pattern_t seg,
    output logic [15:0]                led
);
    import mmio_map_pkg::*;

    seg_word_u   seg_q;
    logic [15:0] led_q;
    logic [7:0]  sw_q;

    // hex digit to segments gfedcba
    function automatic logic [6:0] hex7(input logic [3:0] d);
        case (d)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg_q.raw <= '0;
            led_q     <= '0;
            sw_q      <= '0;
        end else begin
            sw_q <= sw;
            // full word writes, strobes ignored here
            if (dev_ctrl.we && dev_ctrl.sel == DEV_SEG) seg_q.raw <= dev_ctrl.wdata;
            if (dev_ctrl.we && dev_ctrl.sel == DEV_LED) led_q <= dev_ctrl.wdata[15:0];
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            seg[i] = hex7(seg_q.digit[i]);
        end
    end

    assign swt_rdata = sw_q;
    assign seg_rdata = seg_q.raw;
    assign led_rdata = led_q;
    assign led       = led_q;

endmodule

`default_nettype wire

//--- verilog/axil_mmio_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module axil_mmio_fsm #(
    parameter int RAM_WORDS = 256
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  axil_pkg::axil_req_t                axi_req,
    output axil_pkg::axil_rsp_t                axi_rsp,
    output mmio_map_pkg::dev_ctrl_t            dev_ctrl,
    input  mmio_map_pkg::word_t                ram_rdata,
    input  logic [mmio_map_pkg::KB_WIDTH-1:0]  kb_rdata,
    input  logic                               kb_empty,
    input  mmio_map_pkg::word_t                rtc_count,
    input  logic [7:0]                         swt_rdata,
    input  mmio_map_pkg::word_t                seg_rdata,
    input  logic [15:0]                        led_rdata
);
    import mmio_map_pkg::*;
    import axil_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WCOLLECT,
        ST_WRESP,
        ST_RWAIT,
        ST_RRESP
    } state_e;

    localparam logic [29:0] RAM_LO = RAM_BASE[31:2];
    localparam logic [29:0] RAM_HI = RAM_LO + 30'(RAM_WORDS);

    state_e     state;
    logic       live;
    logic       aw_got;
    logic       w_got;
    logic       rd_stage;
    logic       bvalid_q;
    logic       rvalid_q;
    addr_t      aw_addr_q;
    addr_t      ar_addr_q;
    word_t      w_data_q;
    logic [3:0] w_strb_q;
    dev_sel_e   rd_sel_q;
    word_t      rd_peri_q;
    word_t      r_data_q;
    axil_resp_e r_resp_q;
    axil_resp_e b_resp_q;

    logic       awready;
    logic       wready;
    logic       arready;
    logic       aw_fire;
    logic       w_fire;
    logic       ar_fire;
    logic       wr_go;
    logic       wr_ok;
    dev_sel_e   wr_sel;
    dev_sel_e   rd_sel;
    word_t      rd_peri;

    function automatic dev_sel_e decode(input addr_t a);
        logic [29:0] w;
        w = a[31:2];
        if (w >= RAM_LO && w < RAM_HI) return DEV_RAM;
        if (w == KBD_ADDR[31:2]) return DEV_KBD;
        if (w == SWT_ADDR[31:2]) return DEV_SWT;
        if (w == RTC_ADDR[31:2]) return DEV_RTC;
        if (w == SEG_ADDR[31:2]) return DEV_SEG;
        if (w == LED_ADDR[31:2]) return DEV_LED;
        return DEV_NONE;
    endfunction

    // live keeps every ready low until the first edge out of reset
    assign awready = live && (state == ST_IDLE || state == ST_WCOLLECT) && !aw_got;
    assign wready  = live && (state == ST_IDLE || state == ST_WCOLLECT) && !w_got;
    assign arready = live && (state == ST_IDLE);

    assign aw_fire = axi_req.aw.valid && awready;
    assign w_fire  = axi_req.w.valid && wready;
    assign ar_fire = axi_req.ar.valid && arready;

    assign wr_sel = decode(aw_addr_q);
    assign rd_sel = decode(ar_addr_q);
    assign wr_ok  = (wr_sel == DEV_RAM) || (wr_sel == DEV_SEG) || (wr_sel == DEV_LED);
    assign wr_go  = (state == ST_WCOLLECT) && aw_got && w_got;

    always_comb begin
        dev_ctrl.sel       = DEV_NONE;
        dev_ctrl.word_addr = aw_addr_q[31:2];
        dev_ctrl.wdata     = w_data_q;
        dev_ctrl.wstrb     = w_strb_q;
        dev_ctrl.we        = 1'b0;
        dev_ctrl.re        = 1'b0;
        if (wr_go) begin
            dev_ctrl.sel = wr_sel;
            dev_ctrl.we  = wr_ok;
        end else if (state == ST_RWAIT && !rd_stage) begin
            dev_ctrl.sel       = rd_sel;
            dev_ctrl.word_addr = ar_addr_q[31:2];
            // no pop from an empty keyboard buffer
            dev_ctrl.re        = (rd_sel != DEV_KBD) || !kb_empty;
        end
    end

    // everything except RAM is sampled in the access cycle
    always_comb begin
        case (rd_sel)
            DEV_KBD: rd_peri = kb_empty ? '0 : word_t'(kb_rdata);
            DEV_SWT: rd_peri = word_t'(swt_rdata);
            DEV_RTC: rd_peri = rtc_count;
            DEV_SEG: rd_peri = seg_rdata;
            DEV_LED: rd_peri = word_t'(led_rdata);
            default: rd_peri = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            live     <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            rd_stage <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            live <= 1'b1;
            if (aw_fire) aw_got <= 1'b1;
            if (w_fire) w_got <= 1'b1;
            case (state)
                ST_IDLE: begin
                    // a read wins, a write taken alongside waits for it
                    if (ar_fire) begin
                        state    <= ST_RWAIT;
                        rd_stage <= 1'b0;
                    end else if (aw_fire || w_fire) begin
                        state <= ST_WCOLLECT;
                    end
                end
                ST_WCOLLECT: begin
                    if (wr_go) begin
                        state    <= ST_WRESP;
                        bvalid_q <= 1'b1;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                    end
                end
                ST_WRESP: begin
                    if (axi_req.bready) begin
                        bvalid_q <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_RWAIT: begin
                    rd_stage <= !rd_stage;
                    if (rd_stage) begin
                        rvalid_q <= 1'b1;
                        state    <= ST_RRESP;
                    end
                end
                ST_RRESP: begin
                    if (axi_req.rready) begin
                        rvalid_q <= 1'b0;
                        state    <= (aw_got || w_got) ? ST_WCOLLECT : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= axi_req.aw.addr;
        if (w_fire) begin
            w_data_q <= axi_req.w.data;
            w_strb_q <= axi_req.w.strb;
        end
        if (ar_fire) ar_addr_q <= axi_req.ar.addr;
        if (wr_go) b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (state == ST_RWAIT && !rd_stage) begin
            rd_sel_q  <= rd_sel;
            rd_peri_q <= rd_peri;
        end
        // RAM data is ready one cycle after the access
        if (state == ST_RWAIT && rd_stage) begin
            r_data_q <= (rd_sel_q == DEV_RAM) ? ram_rdata : rd_peri_q;
            r_resp_q <= (rd_sel_q == DEV_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_comb begin
        axi_rsp.awready = awready;
        axi_rsp.wready  = wready;
        axi_rsp.arready = arready;
        axi_rsp.b.resp  = b_resp_q;
        axi_rsp.b.valid = bvalid_q;
        axi_rsp.r.data  = r_data_q;
        axi_rsp.r.resp  = r_resp_q;
        axi_rsp.r.valid = rvalid_q;
    end

endmodule

`default_nettype wire

//--- verilog/mmio_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmio_top #(
    parameter int RAM_WORDS = 256,
    parameter int KBD_DEPTH = 4,
    parameter int RTC_DIV   = 10
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axil_pkg::axil_req_t        axi_req,
    output axil_pkg::axil_rsp_t        axi_rsp,
    input  logic [7:0]                 kb_code,
    input  logic                       kb_valid,
    input  logic [7:0]                 sw,
    output mmio_map_pkg::seg_pattern_t seg,
    output logic [15:0]                led
);
    import mmio_map_pkg::*;

    dev_ctrl_t           dev_ctrl;
    word_t               ram_rdata;
    logic [KB_WIDTH-1:0] kb_rdata;
    logic                kb_empty;
    logic                kb_pop;
    word_t               rtc_count;
    logic [7:0]          swt_rdata;
    word_t               seg_rdata;
    logic [15:0]         led_rdata;

    // the FSM only raises re on the keyboard when a code is waiting
    assign kb_pop = dev_ctrl.re && (dev_ctrl.sel == DEV_KBD);

    axil_mmio_fsm #(.RAM_WORDS(RAM_WORDS)) u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp),
        .dev_ctrl  (dev_ctrl),
        .ram_rdata (ram_rdata),
        .kb_rdata  (kb_rdata),
        .kb_empty  (kb_empty),
        .rtc_count (rtc_count),
        .swt_rdata (swt_rdata),
        .seg_rdata (seg_rdata),
        .led_rdata (led_rdata)
    );

    mmio_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk      (clk),
        .dev_ctrl (dev_ctrl),
        .rdata    (ram_rdata)
    );

    kbd_fifo #(.KBD_DEPTH(KBD_DEPTH)) u_kbd (
        .clk      (clk),
        .rst_n    (rst_n),
        .kb_code  (kb_code),
        .kb_valid (kb_valid),
        .pop      (kb_pop),
        .rdata    (kb_rdata),
        .empty    (kb_empty)
    );

    rtc_counter #(.RTC_DIV(RTC_DIV)) u_rtc (
        .clk   (clk),
        .rst_n (rst_n),
        .count (rtc_count)
    );

    periph_regs u_periph (
        .clk       (clk),
        .rst_n     (rst_n),
        .dev_ctrl  (dev_ctrl),
        .sw        (sw),
        .swt_rdata (swt_rdata),
        .seg_rdata (seg_rdata),
        .led_rdata (led_rdata),
        .seg       (seg),
        .led       (led)
    );

endmodule

`default_nettype wire

//--- verification/mmio_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module mmio_asserts (
    input logic                clk,
    input logic                rst_n,
    input axil_pkg::axil_req_t axi_req,
    input axil_pkg::axil_rsp_t axi_rsp
);

    int   error_count = 0;
    logic ar_fire;
    logic any_ready;

    assign ar_fire   = axi_req.ar.valid && axi_rsp.arready;
    assign any_ready = axi_rsp.awready || axi_rsp.wready || axi_rsp.arready;

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rsp.b.valid && !axi_req.bready |=> axi_rsp.b.valid)
        else begin
            error_count++;
            $error("bvalid dropped before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rsp.r.valid && !axi_req.rready |=> axi_rsp.r.valid)
        else begin
            error_count++;
            $error("rvalid dropped before rready");
        end

    // data and response frozen during a stall
    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rsp.r.valid && !axi_req.rready |=>
            $stable(axi_rsp.r.data) && $stable(axi_rsp.r.resp))
        else begin
            error_count++;
            $error("read data changed while stalled");
        end

    // rvalid set on the second edge after the AR transfer
    r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ar_fire |=> !axi_rsp.r.valid ##1 !axi_rsp.r.valid ##1 axi_rsp.r.valid)
        else begin
            error_count++;
            $error("rvalid did not follow the AR transfer by two cycles");
        end

    no_ready_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (axi_rsp.b.valid || axi_rsp.r.valid) |-> !any_ready)
        else begin
            error_count++;
            $error("ready high while a response is pending");
        end

endmodule

bind axil_mmio_fsm mmio_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp)
);

`default_nettype wire

//--- verification/mmio_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mmio_tb;
    import mmio_map_pkg::*;
    import axil_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_LINE = 40;

    // standard hex digit patterns with segment a in bit 0
    localparam logic [6:0] HEX_SEGS [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic         clk;
    logic         rst_n;
    axil_req_t    req;
    axil_rsp_t    rsp;
    logic [7:0]   kb_code;
    logic         kb_valid;
    logic [7:0]   sw;
    seg_pattern_t seg;
    logic [15:0]  led;

    // one entry per trace line
    string      t_op[$];
    addr_t      t_addr[$];
    word_t      t_data[$];
    logic [3:0] t_strb[$];
    axil_resp_e t_resp[$];
    word_t      t_exp[$];
    string      t_name[$];

    integer seed;
    int     resp_errors;
    int     data_errors;
    int     port_errors;
    int     other_errors;
    bit     loaded;
    string  cur_name;

    mmio_top #(
        .RAM_WORDS (256),
        .KBD_DEPTH (4),
        .RTC_DIV   (10)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .axi_req  (req),
        .axi_rsp  (rsp),
        .kb_code  (kb_code),
        .kb_valid (kb_valid),
        .sw       (sw),
        .seg      (seg),
        .led      (led)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
        if (act !== exp) begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            resp_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_pattern_t exp,
                             input seg_pattern_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            port_errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            port_errors++;
        end
    endtask

    task automatic load_trace();
        int         fd;
        int         n;
        string      line;
        string      op;
        string      name;
        addr_t      a;
        word_t      d;
        logic [3:0] s;
        logic [1:0] r;
        word_t      e;
        fd = $fopen("verification/mmio_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file verification/mmio_trace.txt could not be opened");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip blank and comment lines
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %h %h %h %h %h %s", op, a, d, s, r, e, name);
                if (n == 7) begin
                    t_op.push_back(op);
                    t_addr.push_back(a);
                    t_data.push_back(d);
                    t_strb.push_back(s);
                    t_resp.push_back(axil_resp_e'(r));
                    t_exp.push_back(e);
                    t_name.push_back(name);
                end else begin
                    $display("trace line could not be parsed: %s", line);
                    other_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // called and returns on a falling edge
    task automatic write_bus(input addr_t a, input word_t d, input logic [3:0] s,
                             output axil_resp_e resp);
        bit aw_hit;
        bit w_hit;
        bit b_hit;
        req.aw.addr  = a;
        req.aw.valid = 1'b1;
        req.w.data   = d;
        req.w.strb   = s;
        req.w.valid  = 1'b1;
        while (req.aw.valid || req.w.valid) begin
            aw_hit = req.aw.valid && rsp.awready;
            w_hit  = req.w.valid && rsp.wready;
            @(negedge clk);
            if (aw_hit) req.aw.valid = 1'b0;
            if (w_hit) req.w.valid = 1'b0;
        end
        b_hit = 1'b0;
        while (!b_hit) begin
            // bready held back about one cycle in four
            req.bready = ($random(seed) & 3) != 0;
            b_hit      = req.bready && rsp.b.valid;
            resp       = rsp.b.resp;
            @(negedge clk);
        end
        req.bready = 1'b0;
        if (rsp.b.valid) begin
            $display("write response of %s was still valid after its handshake", cur_name);
            other_errors++;
        end
    endtask

    task automatic read_bus(input addr_t a, output word_t d, output axil_resp_e resp);
        bit ar_hit;
        bit r_hit;
        req.ar.addr  = a;
        req.ar.valid = 1'b1;
        while (req.ar.valid) begin
            ar_hit = rsp.arready;
            @(negedge clk);
            if (ar_hit) req.ar.valid = 1'b0;
        end
        r_hit = 1'b0;
        while (!r_hit) begin
            req.rready = ($random(seed) & 3) != 0;
            r_hit      = req.rready && rsp.r.valid;
            d          = rsp.r.data;
            resp       = rsp.r.resp;
            @(negedge clk);
        end
        req.rready = 1'b0;
        if (rsp.r.valid) begin
            $display("read response of %s was still valid after its handshake", cur_name);
            other_errors++;
        end
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (t_op.size() * CYCLES_PER_LINE + RESET_CYCLES + 2) @(posedge clk);
        $display("timeout, no handshake completed in test %s", cur_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main_seq
        word_t        rd;
        word_t        wd;
        word_t        last_rtc;
        bit           have_rtc;
        axil_resp_e   resp;
        seg_pattern_t exp_seg;
        int           assert_errors;
        int           total;
        seed         = 32'h301f_179e;
        rst_n        = 1'b0;
        req          = '0;
        kb_code      = '0;
        kb_valid     = 1'b0;
        sw           = '0;
        have_rtc     = 1'b0;
        last_rtc     = '0;
        cur_name     = "reset";
        resp_errors  = 0;
        data_errors  = 0;
        port_errors  = 0;
        other_errors = 0;
        load_trace();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < t_op.size(); i++) begin
            cur_name = t_name[i];
            wd       = t_data[i];
            if (t_op[i] == "W") begin
                write_bus(t_addr[i], wd, t_strb[i], resp);
                check_resp(t_name[i], t_resp[i], resp);
                if (t_addr[i] == SEG_ADDR) begin
                    for (int k = 0; k < 8; k++) begin
                        exp_seg[k] = HEX_SEGS[wd[4*k +: 4]];
                    end
                    check_seg(t_name[i], exp_seg, seg);
                end
                if (t_addr[i] == LED_ADDR) check_led(t_name[i], wd[15:0], led);
            end else if (t_op[i] == "R") begin
                read_bus(t_addr[i], rd, resp);
                check_resp(t_name[i], t_resp[i], resp);
                if (t_addr[i] == RTC_ADDR) begin
                    // counter reads are only compared with each other
                    if (have_rtc && rd <= last_rtc) begin
                        $display("rtc count did not increase in %s, %h after %h",
                                 t_name[i], rd, last_rtc);
                        data_errors++;
                    end
                    last_rtc = rd;
                    have_rtc = 1'b1;
                end else begin
                    check_word(t_name[i], t_exp[i], rd);
                end
            end else if (t_op[i] == "K") begin
                kb_code  = wd[7:0];
                kb_valid = 1'b1;
                @(negedge clk);
                kb_valid = 1'b0;
            end else if (t_op[i] == "S") begin
                sw = wd[7:0];
                @(negedge clk);
            end else begin
                $display("unknown operation %s in trace line %s", t_op[i], t_name[i]);
                other_errors++;
            end
        end
        assert_errors = uut.u_fsm.u_asserts.error_count;
        total = resp_errors + data_errors + port_errors + other_errors + assert_errors;
        $display("errors: response %0d data %0d outputs %0d protocol %0d assertions %0d",
                 resp_errors, data_errors, port_errors, other_errors, assert_errors);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mmio_trace.txt
# op addr data strb resp expected_data name
# op W write, R read, K key push, S set switches; resp 0 OKAY, 2 SLVERR; all values hex
W 00000000 11223344 f 0 00000000 ram_full0
W 00000004 aabbccdd f 0 00000000 ram_full1
W 00000004 00005500 2 0 00000000 ram_byte1
W 00000000 99887766 c 0 00000000 ram_half_hi
R 00000000 00000000 0 0 99883344 ram_read0
R 00000004 00000000 0 0 aabb55dd ram_read1
R 00001008 00000000 0 0 00000000 rtc_first
W 00001010 0123abcd f 0 00000000 seg_write
R 00001010 00000000 0 0 0123abcd seg_read
W 00001014 1234beef 3 0 00000000 led_write
R 00001014 00000000 0 0 0000beef led_read
R 00001008 00000000 0 0 00000000 rtc_second
K 00000000 0000001c 0 0 00000000 key_push0
K 00000000 00000032 0 0 00000000 key_push1
K 00000000 00000021 0 0 00000000 key_push2
W 00001000 000000ff f 2 00000000 kbd_write_ro
R 00001000 00000000 0 0 0000001c kbd_read0
R 00001000 00000000 0 0 00000032 kbd_read1
R 00001000 00000000 0 0 00000021 kbd_read2
R 00001000 00000000 0 0 00000000 kbd_read_empty
S 00000000 000000a5 0 0 00000000 sw_set
R 00001004 00000000 0 0 000000a5 sw_read
W 00001004 000000ff f 2 00000000 sw_write_ro
R 00001004 00000000 0 0 000000a5 sw_read_again
R 00002000 00000000 0 2 00000000 unmapped_read
W 00003000 12345678 f 2 00000000 unmapped_write

//--- mmio.f
verilog/mmio_map_pkg.sv
verilog/axil_pkg.sv
verilog/mmio_ram.sv
verilog/kbd_fifo.sv
verilog/rtc_counter.sv
verilog/periph_regs.sv
verilog/axil_mmio_fsm.sv
verilog/mmio_top.sv
verification/mmio_asserts.sv
verification/mmio_tb.sv

//--- Bender.yml
package:
  name: mmio

sources:
  - verilog/mmio_map_pkg.sv
  - verilog/axil_pkg.sv
  - verilog/mmio_ram.sv
  - verilog/kbd_fifo.sv
  - verilog/rtc_counter.sv
  - verilog/periph_regs.sv
  - verilog/axil_mmio_fsm.sv
  - verilog/mmio_top.sv
  - target: simulation
    files:
      - verification/mmio_asserts.sv
      - verification/mmio_tb.sv
